// File: rtl/cuPkg.sv
package cuPkg;

	// Instruction word layout
	localparam int WordWidth = 32;
	localparam int OpcodeMsb = 31; // Opcode sits in the top five bits
	localparam int OpcodeLsb = 27;

	typedef logic [WordWidth-1:0] word_t;
	typedef logic [OpcodeMsb-OpcodeLsb:0] opcode_t;
	typedef logic [2:0] step_t; // Step 0..2 is fetch, execute runs 3..7
	typedef logic [5:0] divCount_t; // Must hold DivWaitCycles

	localparam step_t FirstExecStep = 3'd3;
	localparam int DivWaitCycles = 32; // Divider needs one cycle per quotient bit

	// Opcode values, same numbering as the instruction set sheet
	localparam opcode_t OpLd   = 5'd0;
	localparam opcode_t OpLdi  = 5'd1;
	localparam opcode_t OpSt   = 5'd2;
	localparam opcode_t OpAdd  = 5'd3;
	localparam opcode_t OpSub  = 5'd4;
	localparam opcode_t OpAnd  = 5'd5;
	localparam opcode_t OpOr   = 5'd6;
	localparam opcode_t OpRor  = 5'd7;
	localparam opcode_t OpRol  = 5'd8;
	localparam opcode_t OpShr  = 5'd9;
	localparam opcode_t OpShra = 5'd10;
	localparam opcode_t OpShl  = 5'd11;
	localparam opcode_t OpAddi = 5'd12; // Immediate forms take C from the IR
	localparam opcode_t OpAndi = 5'd13;
	localparam opcode_t OpOri  = 5'd14;
	localparam opcode_t OpDiv  = 5'd15;
	localparam opcode_t OpMul  = 5'd16;
	localparam opcode_t OpNeg  = 5'd17;
	localparam opcode_t OpNot  = 5'd18;
	localparam opcode_t OpBr   = 5'd19;
	localparam opcode_t OpJal  = 5'd20;
	localparam opcode_t OpJr   = 5'd21;
	localparam opcode_t OpIn   = 5'd22;
	localparam opcode_t OpOut  = 5'd23;
	localparam opcode_t OpMflo = 5'd24;
	localparam opcode_t OpMfhi = 5'd25;
	localparam opcode_t OpNop  = 5'd26;
	localparam opcode_t OpHalt = 5'd27; // 28..31 are unassigned

	// Sequencer states
	typedef enum logic [2:0] {
		sReset,
		sFetch0,
		sFetch1,
		sFetch2,
		sExec,
		sStopped // Held until reset
	} seqState_t;

	// Instructions grouped by their execute sequence
	typedef enum logic [4:0] {
		icLoad,
		icLoadImm,
		icStore,
		icAluReg,
		icAluImm,
		icMul,
		icDiv,
		icUnary, // neg and not
		icBranch,
		icJal,
		icJr,
		icIn,
		icOut,
		icMfhi,
		icMflo,
		icNop,
		icHalt,
		icIllegal
	} instrClass_t;

	// ALU operation field
	typedef enum logic [3:0] {
		aluNone,
		aluAdd,
		aluSub,
		aluMul,
		aluDiv,
		aluShr,
		aluShra,
		aluShl,
		aluRor,
		aluRol,
		aluAnd,
		aluOr,
		aluNeg,
		aluNot
	} aluOp_t;

endpackage

// File: rtl/opcodeDecode.sv
`timescale 1ns/1ps

module opcodeDecode (
	input  cuPkg::word_t       irContents,
	output cuPkg::instrClass_t instrClass,
	output cuPkg::aluOp_t      execAluOp,
	output cuPkg::step_t       lastStep,
	output cuPkg::step_t       longStep,
	output logic               stopAfter,
	output logic               illegal
);

	cuPkg::opcode_t opcode;

	assign opcode = irContents[cuPkg::OpcodeMsb:cuPkg::OpcodeLsb];

	// Opcode to instruction class
	always_comb begin
		case (opcode)
			cuPkg::OpLd: instrClass = cuPkg::icLoad;
			cuPkg::OpLdi: instrClass = cuPkg::icLoadImm;
			cuPkg::OpSt: instrClass = cuPkg::icStore;
			cuPkg::OpAdd, cuPkg::OpSub, cuPkg::OpAnd, cuPkg::OpOr,
			cuPkg::OpRor, cuPkg::OpRol, cuPkg::OpShr, cuPkg::OpShra,
			cuPkg::OpShl: instrClass = cuPkg::icAluReg;
			cuPkg::OpAddi, cuPkg::OpAndi, cuPkg::OpOri: instrClass = cuPkg::icAluImm;
			cuPkg::OpDiv: instrClass = cuPkg::icDiv;
			cuPkg::OpMul: instrClass = cuPkg::icMul;
			cuPkg::OpNeg, cuPkg::OpNot: instrClass = cuPkg::icUnary;
			cuPkg::OpBr: instrClass = cuPkg::icBranch;
			cuPkg::OpJal: instrClass = cuPkg::icJal;
			cuPkg::OpJr: instrClass = cuPkg::icJr;
			cuPkg::OpIn: instrClass = cuPkg::icIn;
			cuPkg::OpOut: instrClass = cuPkg::icOut;
			cuPkg::OpMflo: instrClass = cuPkg::icMflo;
			cuPkg::OpMfhi: instrClass = cuPkg::icMfhi;
			cuPkg::OpNop: instrClass = cuPkg::icNop;
			cuPkg::OpHalt: instrClass = cuPkg::icHalt;
			default: instrClass = cuPkg::icIllegal; // Unassigned opcode
		endcase
	end

	// Operation applied in the compute step
	always_comb begin
		case (opcode)
			cuPkg::OpLd, cuPkg::OpLdi, cuPkg::OpSt, cuPkg::OpAdd,
			cuPkg::OpAddi, cuPkg::OpBr: execAluOp = cuPkg::aluAdd; // Address and offset sums
			cuPkg::OpSub: execAluOp = cuPkg::aluSub;
			cuPkg::OpAnd, cuPkg::OpAndi: execAluOp = cuPkg::aluAnd;
			cuPkg::OpOr, cuPkg::OpOri: execAluOp = cuPkg::aluOr;
			cuPkg::OpRor: execAluOp = cuPkg::aluRor;
			cuPkg::OpRol: execAluOp = cuPkg::aluRol;
			cuPkg::OpShr: execAluOp = cuPkg::aluShr;
			cuPkg::OpShra: execAluOp = cuPkg::aluShra;
			cuPkg::OpShl: execAluOp = cuPkg::aluShl;
			cuPkg::OpDiv: execAluOp = cuPkg::aluDiv;
			cuPkg::OpMul: execAluOp = cuPkg::aluMul;
			cuPkg::OpNeg: execAluOp = cuPkg::aluNeg;
			cuPkg::OpNot: execAluOp = cuPkg::aluNot;
			default: execAluOp = cuPkg::aluNone;
		endcase
	end

	// Length of each execute sequence
	always_comb begin
		case (instrClass)
			cuPkg::icLoad, cuPkg::icStore: lastStep = 3'd7;
			cuPkg::icLoadImm, cuPkg::icAluReg, cuPkg::icAluImm: lastStep = 3'd5;
			cuPkg::icMul, cuPkg::icDiv, cuPkg::icBranch: lastStep = 3'd6;
			cuPkg::icUnary, cuPkg::icJal: lastStep = 3'd4;
			default: lastStep = cuPkg::FirstExecStep; // Single-row instructions
		endcase
	end

	assign longStep = (instrClass == cuPkg::icDiv) ? 3'd4 : 3'd0; // 0 never matches in execute
	assign stopAfter = (instrClass == cuPkg::icHalt);
	assign illegal = (instrClass == cuPkg::icIllegal);

endmodule

// File: rtl/stepSequencer.sv
`timescale 1ns/1ps

module stepSequencer (
	input  logic             clk,
	input  logic             reset,
	input  cuPkg::step_t     lastStep,
	input  cuPkg::step_t     longStep,
	input  logic             stopAfter,
	input  logic             illegal,
	output cuPkg::seqState_t state,
	output cuPkg::step_t     step,
	output logic             stepFirst
);

	cuPkg::seqState_t stateNext;
	cuPkg::step_t stepNext;
	cuPkg::divCount_t divCount; // Extra cycles spent in the long step
	cuPkg::divCount_t divCountNext;
	logic inLongStep;
	logic divDone;

	assign inLongStep = (state == cuPkg::sExec) && (step == longStep);
	assign divDone = (divCount == cuPkg::divCount_t'(cuPkg::DivWaitCycles));

	// Only the opening cycle of the stretched step
	assign stepFirst = inLongStep && (divCount == '0);

	always_comb begin
		stateNext = state;
		stepNext = step;
		divCountNext = '0; // Cleared whenever the long step is not in progress
		case (state)
			cuPkg::sReset: begin
				stateNext = cuPkg::sFetch0;
			end
			cuPkg::sFetch0: begin
				stateNext = cuPkg::sFetch1;
			end
			cuPkg::sFetch1: begin
				stateNext = cuPkg::sFetch2;
			end
			cuPkg::sFetch2: begin
				// IR loads on this edge
				stateNext = cuPkg::sExec;
				stepNext = cuPkg::FirstExecStep;
			end
			cuPkg::sExec: begin
				if (illegal) begin
					stateNext = cuPkg::sReset; // Restart with a fresh clear pulse
				end else if (stopAfter) begin
					stateNext = cuPkg::sStopped;
				end else if (inLongStep && !divDone) begin
					divCountNext = divCount + 1'b1; // Hold the step while the divider runs
				end else if (step == lastStep) begin
					stateNext = cuPkg::sFetch0;
				end else begin
					stepNext = step + 1'b1;
				end
			end
			cuPkg::sStopped: begin
				stateNext = cuPkg::sStopped; // Only reset leaves here
			end
			default: begin
				stateNext = cuPkg::sReset;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= cuPkg::sReset;
			step <= cuPkg::FirstExecStep;
			divCount <= '0;
		end else begin
			state <= stateNext;
			step <= stepNext;
			divCount <= divCountNext;
		end
	end

endmodule

// File: rtl/controlWordGen.sv
`timescale 1ns/1ps

module controlWordGen (
	input  cuPkg::seqState_t   state,
	input  cuPkg::step_t       step,
	input  logic               stepFirst,
	input  cuPkg::instrClass_t instrClass,
	input  cuPkg::aluOp_t      execAluOp,
	input  logic               conFf,
	// Register loads from the bus
	output logic rIn, hiIn, loIn, conIn, pcIn, irIn, yIn, zIn, marIn, mdrIn, outportIn,
	// Bus drivers
	output logic rOut, mdrOut, hiOut, loOut, zHiOut, zLoOut, pcOut, cOut, inportOut,
	// Register file selects
	output logic gra, grb, grc, baOut,
	output logic read, write, run, clear, incPc, resetDivision,
	output cuPkg::aluOp_t aluOp
);

	logic aluStep; // Compute step of the current instruction

	assign aluOp = aluStep ? execAluOp : cuPkg::aluNone;

	always_comb begin
		{rIn, hiIn, loIn, conIn, pcIn, irIn, yIn, zIn, marIn, mdrIn, outportIn,
			rOut, mdrOut, hiOut, loOut, zHiOut, zLoOut, pcOut, cOut, inportOut,
			gra, grb, grc, baOut, read, write, incPc, resetDivision, aluStep} = '0;
		clear = (state == cuPkg::sReset);
		run = (state != cuPkg::sStopped); // Halt row below also drops it
		case (state)
			cuPkg::sFetch0: begin
				pcOut = 1'b1;
				marIn = 1'b1;
				zIn = 1'b1;
			end
			cuPkg::sFetch1: begin
				zLoOut = 1'b1; // Incremented PC back into PC
				pcIn = 1'b1;
				read = 1'b1;
				mdrIn = 1'b1;
			end
			cuPkg::sFetch2: begin
				mdrOut = 1'b1;
				irIn = 1'b1;
				incPc = 1'b1;
			end
			cuPkg::sExec: begin
				case (step)
					cuPkg::FirstExecStep: begin
						case (instrClass)
							cuPkg::icLoad, cuPkg::icLoadImm, cuPkg::icStore: begin
								grb = 1'b1;
								baOut = 1'b1; // R0 reads as zero for the base
								rOut = 1'b1;
								yIn = 1'b1;
							end
							cuPkg::icAluReg, cuPkg::icAluImm, cuPkg::icMul, cuPkg::icDiv: begin
								grb = 1'b1;
								rOut = 1'b1;
								yIn = 1'b1;
							end
							cuPkg::icUnary: begin
								grb = 1'b1;
								rOut = 1'b1;
								yIn = 1'b1;
								zIn = 1'b1;
								aluStep = 1'b1; // Single operand so it computes right away
							end
							cuPkg::icBranch: begin
								gra = 1'b1;
								rOut = 1'b1;
								conIn = 1'b1; // Evaluate the condition into CON FF
							end
							cuPkg::icJal: begin
								zLoOut = 1'b1; // Z still holds the return address
								gra = 1'b1;
								rIn = 1'b1;
							end
							cuPkg::icJr: begin
								gra = 1'b1;
								rOut = 1'b1;
								pcIn = 1'b1;
							end
							cuPkg::icIn: begin
								gra = 1'b1;
								rIn = 1'b1;
								inportOut = 1'b1;
							end
							cuPkg::icOut: begin
								gra = 1'b1;
								rOut = 1'b1;
								outportIn = 1'b1;
							end
							cuPkg::icMfhi: begin
								gra = 1'b1;
								rIn = 1'b1;
								hiOut = 1'b1;
							end
							cuPkg::icMflo: begin
								gra = 1'b1;
								rIn = 1'b1;
								loOut = 1'b1;
							end
							cuPkg::icHalt: run = 1'b0;
							default: ; // nop and unknown opcodes drive nothing
						endcase
					end
					3'd4: begin
						case (instrClass)
							cuPkg::icLoad, cuPkg::icLoadImm, cuPkg::icStore, cuPkg::icAluImm: begin
								cOut = 1'b1; // Sign-extended constant from the IR
								zIn = 1'b1;
								aluStep = 1'b1;
							end
							cuPkg::icAluReg: begin
								grc = 1'b1;
								rOut = 1'b1;
								zIn = 1'b1;
								aluStep = 1'b1;
							end
							cuPkg::icMul, cuPkg::icDiv: begin
								gra = 1'b1;
								rOut = 1'b1;
								zIn = 1'b1;
								aluStep = 1'b1;
								resetDivision = stepFirst; // Only div has a first cycle flagged
							end
							cuPkg::icUnary: begin
								zLoOut = 1'b1;
								gra = 1'b1;
								rIn = 1'b1;
							end
							cuPkg::icBranch: begin
								pcOut = 1'b1;
								yIn = 1'b1;
							end
							cuPkg::icJal: begin
								gra = 1'b1;
								rOut = 1'b1;
								pcIn = 1'b1;
							end
							default: ;
						endcase
					end
					3'd5: begin
						case (instrClass)
							cuPkg::icLoad, cuPkg::icStore: begin
								zLoOut = 1'b1; // Effective address into MAR
								marIn = 1'b1;
							end
							cuPkg::icLoadImm, cuPkg::icAluReg, cuPkg::icAluImm: begin
								zLoOut = 1'b1;
								gra = 1'b1;
								rIn = 1'b1;
							end
							cuPkg::icMul, cuPkg::icDiv: begin
								zLoOut = 1'b1;
								loIn = 1'b1;
							end
							cuPkg::icBranch: begin
								cOut = 1'b1; // PC plus displacement
								zIn = 1'b1;
								aluStep = 1'b1;
							end
							default: ;
						endcase
					end
					3'd6: begin
						case (instrClass)
							cuPkg::icLoad: begin
								read = 1'b1;
								mdrIn = 1'b1;
							end
							cuPkg::icStore: begin
								gra = 1'b1;
								rOut = 1'b1;
								mdrIn = 1'b1;
							end
							cuPkg::icMul, cuPkg::icDiv: begin
								zHiOut = 1'b1;
								hiIn = 1'b1;
							end
							cuPkg::icBranch: begin
								zLoOut = 1'b1;
								pcIn = conFf; // Taken only when the condition held
							end
							default: ;
						endcase
					end
					3'd7: begin
						if (instrClass == cuPkg::icLoad) begin
							mdrOut = 1'b1;
							gra = 1'b1;
							rIn = 1'b1;
						end else if (instrClass == cuPkg::icStore) begin
							write = 1'b1;
						end
					end
					default: ;
				endcase
			end
			default: ; // Reset and stopped rows come from the defaults
		endcase
	end

endmodule

// File: rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input  logic         clk,
	input  logic         reset,
	input  cuPkg::word_t irContents, // IR output, stable during execute
	input  logic         conFf,
	output logic rIn, hiIn, loIn, conIn, pcIn, irIn, yIn, zIn, marIn, mdrIn, outportIn,
	output logic rOut, mdrOut, hiOut, loOut, zHiOut, zLoOut, pcOut, cOut, inportOut,
	output logic gra, grb, grc, baOut,
	output logic read, write, run, clear, incPc, resetDivision,
	output cuPkg::aluOp_t aluOp
);

	cuPkg::instrClass_t instrClass;
	cuPkg::aluOp_t execAluOp;
	cuPkg::step_t lastStep;
	cuPkg::step_t longStep;
	logic stopAfter;
	logic illegal;
	cuPkg::seqState_t state;
	cuPkg::step_t step;
	logic stepFirst;

	opcodeDecode decode0 (
		.irContents(irContents),
		.instrClass(instrClass),
		.execAluOp(execAluOp),
		.lastStep(lastStep),
		.longStep(longStep),
		.stopAfter(stopAfter),
		.illegal(illegal)
	);

	stepSequencer seq0 (
		.clk(clk),
		.reset(reset),
		.lastStep(lastStep),
		.longStep(longStep),
		.stopAfter(stopAfter),
		.illegal(illegal),
		.state(state),
		.step(step),
		.stepFirst(stepFirst)
	);

	// Strobe names match the top ports one to one
	controlWordGen ctrlGen0 (.*);

endmodule

// File: tb/controlUnitAsserts.sv
`timescale 1ns/1ps

module controlUnitAsserts (
	input logic clk,
	input logic reset,
	input logic read,
	input logic write,
	input logic run,
	input logic rOut, mdrOut, zLoOut, zHiOut, pcOut, cOut, hiOut, loOut, inportOut
);

	int assertFailures = 0; // Read by the testbench summary

	// Memory never reads and writes in the same cycle
	memExclusive: assert property (@(posedge clk) disable iff (reset) !(read && write))
		else begin
			$error("read and write are high in the same cycle");
			assertFailures++;
		end

	// Once halted, run stays low until reset
	haltHolds: assert property (@(posedge clk) disable iff (reset) !run |=> !run)
		else begin
			$error("run went high again after halt without a reset");
			assertFailures++;
		end

	// One bus driver at most
	busSingleDriver: assert property (@(posedge clk) disable iff (reset)
		$onehot0({rOut, mdrOut, zLoOut, zHiOut, pcOut, cOut, hiOut, loOut, inportOut}))
		else begin
			$error("more than one source drives the bus");
			assertFailures++;
		end

endmodule

bind controlUnit controlUnitAsserts asserts0 (.*);

// File: tb/cuRefModel.svh
`ifndef CU_REF_MODEL_SVH
`define CU_REF_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsrNext(input logic [15:0] s);
	return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic cuPkg::opcode_t opcodeOf(input cuPkg::word_t w);
	return w[cuPkg::OpcodeMsb:cuPkg::OpcodeLsb];
endfunction

function automatic logic unknownOp(input cuPkg::opcode_t op);
	return op > cuPkg::OpHalt; // 28..31 unassigned
endfunction

// Execute cycles per instruction, divide wait included
function automatic int execCycles(input cuPkg::opcode_t op);
	case (op)
		cuPkg::OpLd, cuPkg::OpSt: return 5;
		cuPkg::OpLdi, cuPkg::OpAdd, cuPkg::OpSub, cuPkg::OpAnd, cuPkg::OpOr,
		cuPkg::OpRor, cuPkg::OpRol, cuPkg::OpShr, cuPkg::OpShra, cuPkg::OpShl,
		cuPkg::OpAddi, cuPkg::OpAndi, cuPkg::OpOri: return 3;
		cuPkg::OpMul, cuPkg::OpBr: return 4;
		cuPkg::OpDiv: return 4 + cuPkg::DivWaitCycles;
		cuPkg::OpNeg, cuPkg::OpNot, cuPkg::OpJal: return 2;
		default: return 1; // One-row instructions, halt, unknown
	endcase
endfunction

// Operation of the compute step
function automatic cuPkg::aluOp_t aluFor(input cuPkg::opcode_t op);
	case (op)
		cuPkg::OpAdd, cuPkg::OpAddi: return cuPkg::aluAdd;
		cuPkg::OpSub: return cuPkg::aluSub;
		cuPkg::OpAnd, cuPkg::OpAndi: return cuPkg::aluAnd;
		cuPkg::OpOr, cuPkg::OpOri: return cuPkg::aluOr;
		cuPkg::OpRor: return cuPkg::aluRor;
		cuPkg::OpRol: return cuPkg::aluRol;
		cuPkg::OpShr: return cuPkg::aluShr;
		cuPkg::OpShra: return cuPkg::aluShra;
		cuPkg::OpShl: return cuPkg::aluShl;
		cuPkg::OpMul: return cuPkg::aluMul;
		cuPkg::OpDiv: return cuPkg::aluDiv;
		cuPkg::OpNeg: return cuPkg::aluNeg;
		cuPkg::OpNot: return cuPkg::aluNot;
		default: return cuPkg::aluNone;
	endcase
endfunction

// Expected strobes and aluOp; cycle -1 is the reset row, 0..2 fetch, 3 up execute
function automatic logic [33:0] expectedWord(input cuPkg::opcode_t op, input int cycle,
		input logic cond);
	logic rIn, hiIn, loIn, conIn, pcIn, irIn, yIn, zIn, marIn, mdrIn, outportIn;
	logic rOut, mdrOut, hiOut, loOut, zHiOut, zLoOut, pcOut, cOut, inportOut;
	logic gra, grb, grc, baOut, read, write, run, clear, incPc, resetDivision;
	cuPkg::aluOp_t alu;
	int s;
	logic first;
	{rIn, hiIn, loIn, conIn, pcIn, irIn, yIn, zIn, marIn, mdrIn, outportIn,
		rOut, mdrOut, hiOut, loOut, zHiOut, zLoOut, pcOut, cOut, inportOut,
		gra, grb, grc, baOut, read, write, clear, incPc, resetDivision} = '0;
	run = 1'b1;
	alu = cuPkg::aluNone;
	if (cycle < 0) begin
		clear = 1'b1;
	end else if (cycle == 0) begin
		{pcOut, marIn, zIn} = '1;
	end else if (cycle == 1) begin
		{zLoOut, pcIn, read, mdrIn} = '1;
	end else if (cycle == 2) begin
		{mdrOut, irIn, incPc} = '1;
	end else begin
		s = cycle;
		if (op == cuPkg::OpDiv && cycle > 4) begin
			// Step 4 spans the divide wait, later steps shift back
			s = (cycle <= 4 + cuPkg::DivWaitCycles) ? 4 : cycle - cuPkg::DivWaitCycles;
		end
		first = (op == cuPkg::OpDiv) && (cycle == 4);
		case (op)
			cuPkg::OpLd, cuPkg::OpLdi, cuPkg::OpSt: begin
				case (s)
					3: {grb, baOut, rOut, yIn} = '1;
					4: begin
						{cOut, zIn} = '1;
						alu = cuPkg::aluAdd; // Base plus offset
					end
					5: begin
						if (op == cuPkg::OpLdi)
							{zLoOut, gra, rIn} = '1;
						else
							{zLoOut, marIn} = '1;
					end
					6: begin
						if (op == cuPkg::OpLd)
							{read, mdrIn} = '1;
						else
							{gra, rOut, mdrIn} = '1; // Store data into MDR
					end
					7: begin
						if (op == cuPkg::OpLd)
							{mdrOut, gra, rIn} = '1;
						else
							write = 1'b1;
					end
					default: ;
				endcase
			end
			cuPkg::OpAdd, cuPkg::OpSub, cuPkg::OpAnd, cuPkg::OpOr, cuPkg::OpRor,
			cuPkg::OpRol, cuPkg::OpShr, cuPkg::OpShra, cuPkg::OpShl,
			cuPkg::OpAddi, cuPkg::OpAndi, cuPkg::OpOri: begin
				if (s == 3) begin
					{grb, rOut, yIn} = '1;
				end else if (s == 4) begin
					zIn = 1'b1;
					alu = aluFor(op);
					if (op >= cuPkg::OpAddi)
						cOut = 1'b1; // Immediate operand
					else
						{grc, rOut} = '1;
				end else begin
					{zLoOut, gra, rIn} = '1;
				end
			end
			cuPkg::OpMul, cuPkg::OpDiv: begin
				case (s)
					3: {grb, rOut, yIn} = '1;
					4: begin
						{gra, rOut, zIn} = '1;
						alu = aluFor(op);
						resetDivision = first;
					end
					5: {zLoOut, loIn} = '1;
					default: {zHiOut, hiIn} = '1;
				endcase
			end
			cuPkg::OpNeg, cuPkg::OpNot: begin
				if (s == 3) begin
					{grb, rOut, yIn, zIn} = '1;
					alu = aluFor(op);
				end else begin
					{zLoOut, gra, rIn} = '1;
				end
			end
			cuPkg::OpBr: begin
				case (s)
					3: {gra, rOut, conIn} = '1;
					4: {pcOut, yIn} = '1;
					5: begin
						{cOut, zIn} = '1;
						alu = cuPkg::aluAdd;
					end
					default: begin
						zLoOut = 1'b1;
						pcIn = cond; // Taken branch only
					end
				endcase
			end
			cuPkg::OpJal: begin
				if (s == 3)
					{zLoOut, gra, rIn} = '1;
				else
					{gra, rOut, pcIn} = '1;
			end
			cuPkg::OpJr: {gra, rOut, pcIn} = '1;
			cuPkg::OpIn: {gra, rIn, inportOut} = '1;
			cuPkg::OpOut: {gra, rOut, outportIn} = '1;
			cuPkg::OpMfhi: {gra, rIn, hiOut} = '1;
			cuPkg::OpMflo: {gra, rIn, loOut} = '1;
			cuPkg::OpHalt: run = 1'b0; // Step 3 and every stopped cycle after it
			default: ; // nop and unknown opcodes
		endcase
	end
	return {rIn, hiIn, loIn, conIn, pcIn, irIn, yIn, zIn, marIn, mdrIn, outportIn,
		rOut, mdrOut, hiOut, loOut, zHiOut, zLoOut, pcOut, cOut, inportOut,
		gra, grb, grc, baOut, read, write, run, clear, incPc, resetDivision, alu};
endfunction

`endif

// File: tb/controlUnitTb.sv
`timescale 1ns/1ps

module controlUnitTb;

	logic clk;
	logic reset;
	logic conFf;
	cuPkg::word_t irContents;
	logic rIn, hiIn, loIn, conIn, pcIn, irIn, yIn, zIn, marIn, mdrIn, outportIn;
	logic rOut, mdrOut, hiOut, loOut, zHiOut, zLoOut, pcOut, cOut, inportOut;
	logic gra, grb, grc, baOut, read, write, run, clear, incPc, resetDivision;
	cuPkg::aluOp_t aluOp;

	logic [15:0] lfsrState;
	logic [31:0] condBits;
	cuPkg::word_t allWords[$]; // Every test's program back to back
	cuPkg::word_t progWords[$]; // Program of the running test
	int testFirst[7];
	int testLen[7];
	int testHold[7]; // Extra cycles after the last instruction
	string testName[7] = '{"reset and fetch", "alu operations", "memory",
		"multiply and divide", "control transfer", "halt and unknown opcode", "random mix"};
	int irIdx;
	int expIdx;
	int doneInstr; // Instructions fully checked in this test
	int cycle; // Cycle within the instruction or -1 for a reset row
	cuPkg::opcode_t expOp;
	logic [1:0] brSeen; // Condition values seen at br step 6
	int errorCount;
	int failedTests;
	int budget;
	logic budgetReady;

	`include "cuRefModel.svh"

	controlUnit dut0 (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic takeBits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsrState[15]};
			lfsrState = lfsrNext(lfsrState); // One step per bit
		end
	endtask

	task automatic appendWord(input cuPkg::opcode_t op);
		logic [31:0] bits;
		takeBits(27, bits); // Register and constant fields
		allWords.push_back({op, bits[26:0]});
	endtask

	task automatic closeTest(input int t, input int hold);
		testFirst[t] = (t == 0) ? 0 : testFirst[t-1] + testLen[t-1];
		testLen[t] = allWords.size() - testFirst[t];
		testHold[t] = hold;
	endtask

	task automatic buildTests();
		logic [31:0] pick;
		cuPkg::opcode_t op;
		int i;
		appendWord(cuPkg::OpNop);
		appendWord(cuPkg::OpNop);
		closeTest(0, 0);
		for (i = cuPkg::OpAdd; i <= cuPkg::OpOri; i++)
			appendWord(cuPkg::opcode_t'(i)); // Register then immediate forms
		closeTest(1, 0);
		appendWord(cuPkg::OpLd);
		appendWord(cuPkg::OpLdi);
		appendWord(cuPkg::OpSt);
		closeTest(2, 0);
		appendWord(cuPkg::OpMul);
		appendWord(cuPkg::OpDiv);
		appendWord(cuPkg::OpMul);
		closeTest(3, 0);
		repeat (6) appendWord(cuPkg::OpBr);
		appendWord(cuPkg::OpJal);
		appendWord(cuPkg::OpJr);
		appendWord(cuPkg::OpIn);
		appendWord(cuPkg::OpOut);
		appendWord(cuPkg::OpMfhi);
		appendWord(cuPkg::OpMflo);
		appendWord(cuPkg::OpNop);
		closeTest(4, 0);
		appendWord(5'd28); // Unassigned
		appendWord(cuPkg::OpNop);
		appendWord(5'd31);
		appendWord(cuPkg::OpAdd);
		appendWord(cuPkg::OpHalt);
		closeTest(5, 40); // Stay stopped for a while
		repeat (12) begin
			takeBits(5, pick);
			op = pick[4:0];
			if (op == cuPkg::OpHalt)
				op = cuPkg::OpNop; // Halt would stall the rest
			appendWord(op);
		end
		closeTest(6, 0);
		// Cycle budget for the watchdog
		budget = 200;
		foreach (allWords[i])
			budget += 4 + execCycles(opcodeOf(allWords[i]));
		foreach (testHold[i])
			budget += 4 + testHold[i];
	endtask

	task automatic runTest(input int t);
		int i;
		@(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		progWords.delete();
		for (i = 0; i < testLen[t]; i++)
			progWords.push_back(allWords[testFirst[t] + i]);
		irIdx = 0;
		expIdx = 0;
		doneInstr = 0;
		brSeen = '0;
		@(posedge clk);
		reset <= 1'b0;
		wait (doneInstr == testLen[t]);
		repeat (testHold[t]) @(posedge clk);
	endtask

	task automatic compareWord(input logic [33:0] exp);
		logic [33:0] got;
		got = {rIn, hiIn, loIn, conIn, pcIn, irIn, yIn, zIn, marIn, mdrIn, outportIn,
			rOut, mdrOut, hiOut, loOut, zHiOut, zLoOut, pcOut, cOut, inportOut,
			gra, grb, grc, baOut, read, write, run, clear, incPc, resetDivision, aluOp};
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t ns: opcode %0d cycle %0d expected %h got %h",
				$time, expOp, cycle, exp, got);
			errorCount++;
		end
	endtask

	// Instruction register model loading on irIn
	always @(posedge clk) begin
		if (irIn) begin
			irContents <= (irIdx < progWords.size()) ? progWords[irIdx] : {cuPkg::OpNop, 27'd0};
			irIdx++;
		end
	end

	// Branch condition gets a new random bit each cycle
	always @(posedge clk) begin
		takeBits(1, condBits);
		conFf <= condBits[0];
	end

	// Compare on the falling edge where outputs are settled
	always @(negedge clk) begin
		if (reset) begin
			cycle = -1;
			compareWord(expectedWord(expOp, -1, conFf));
		end else begin
			if (cycle == int'(cuPkg::FirstExecStep)) begin
				expOp = (expIdx < progWords.size()) ? opcodeOf(progWords[expIdx]) : cuPkg::OpNop;
				expIdx++;
			end
			if (expOp == cuPkg::OpBr && cycle == 6)
				brSeen[conFf] = 1'b1;
			compareWord(expectedWord(expOp, cycle, conFf));
			if (expOp == cuPkg::OpHalt && cycle == 3) begin
				doneInstr++;
				cycle++; // Keeps counting through the stopped cycles
			end else if (cycle == 2 + execCycles(expOp)) begin
				doneInstr++;
				cycle = unknownOp(expOp) ? -1 : 0; // Unknown opcode restarts at the reset row
			end else begin
				cycle++;
			end
		end
	end

	// Watchdog
	initial begin
		wait (budgetReady);
		repeat (budget) @(posedge clk);
		$display("Run timed out after %0d cycles before all tests finished", budget);
		$display("test failed");
		$finish;
	end

	initial begin
		int t;
		int errorsBefore;
		reset = 1'b1;
		conFf = 1'b0;
		irContents = '0;
		lfsrState = 16'd70;
		errorCount = 0;
		failedTests = 0;
		doneInstr = 0;
		cycle = -1;
		expOp = cuPkg::OpNop;
		irIdx = 0;
		expIdx = 0;
		brSeen = '0;
		budgetReady = 1'b0;
		buildTests();
		budgetReady = 1'b1;
		for (t = 0; t < $size(testLen); t++) begin
			errorsBefore = errorCount;
			runTest(t);
			if (t == 4) begin
				assert (brSeen == 2'b11) else begin
					$display("Branch step 6 did not see both values of the condition flag");
					errorCount++;
				end
			end
			if (errorCount == errorsBefore) begin
				$display("Test %0d %s: ok", t + 1, testName[t]);
			end else begin
				failedTests++;
				$display("Test %0d %s: %0d failed checks", t + 1, testName[t],
					errorCount - errorsBefore);
			end
		end
		errorCount += dut0.asserts0.assertFailures; // Bound assertion failures
		$display("Tests passed %0d, tests failed %0d, failed checks %0d",
			$size(testLen) - failedTests, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+tb
rtl/cuPkg.sv
rtl/opcodeDecode.sv
rtl/stepSequencer.sv
rtl/controlWordGen.sv
rtl/controlUnit.sv
tb/controlUnitAsserts.sv
tb/controlUnitTb.sv

// File: Bender.yml
package:
  name: controlUnit

sources:
  - files:
      - rtl/cuPkg.sv
      - rtl/opcodeDecode.sv
      - rtl/stepSequencer.sv
      - rtl/controlWordGen.sv
      - rtl/controlUnit.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/controlUnitAsserts.sv
      - tb/controlUnitTb.sv
